// ==== vlog.f ====
hw/runner_pkg.sv
hw/tick_gen.sv
hw/spawn_picker.sv
hw/obstacle_tracker.sv
hw/hit_detector.sv
hw/score_display.sv
hw/runner_top.sv
sim/runner_tb.sv

// ==== sim/runner_tb.sv ====
module runner_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_ROWS = 4;
	localparam int MOVE_CYCLES = runner_pkg::FRAME_CYCLES * runner_pkg::MOVE_FRAMES;

	logic                    clock;
	logic                    resetn;
	runner_pkg::player_t     player;
	runner_pkg::obstacles_t  obstacles;
	logic                    game_over;
	runner_pkg::score_segs_t score_segs;

	// stimulus table: name, player position, movement ticks, expected game_over
	string row_name [NUM_ROWS] = '{"first_spawn", "slot_fill", "score_carry", "hit_stop"};
	int    row_px   [NUM_ROWS] = '{0, 0, 0, 50};
	int    row_py   [NUM_ROWS] = '{0, 0, 0, 100};
	int    row_moves[NUM_ROWS] = '{30, 260, 200, 200};
	bit    row_over [NUM_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b1};

	// active-low digit patterns, segment a in bit 0
	logic [6:0] digit_segs [10] = '{7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
		7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000, 7'b0000000, 7'b0011000};

	// reference model state, mirrors what the DUT should hold after each edge
	runner_pkg::obstacles_t m_obs = '0;
	int m_cycle        = 0;
	int m_frame        = 0;
	int m_spawn_cnt    = 0;
	int m_height       = 0;
	int m_score_frames = 0;
	int m_score        = 0;
	bit m_over         = 1'b0;

	runner_top i_dut (
		.clock      (clock),
		.resetn     (resetn),
		.player     (player),
		.obstacles  (obstacles),
		.game_over  (game_over),
		.score_segs (score_segs)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			$display("FAIL %s expected %0h actual %0h", name, expected, actual);
			$display("ERRORS FOUND");
			$fatal(1, "first mismatch, run stopped");
		end
	endtask

	function automatic logic [20:0] expected_segs(input int score);
		return {digit_segs[score % 10], digit_segs[(score / 10) % 10],
			digit_segs[(score / 100) % 10]};
	endfunction

	// one clock edge of the model, then the player for the next cycle is driven
	task automatic advance_cycle(input int px, input int py);
		runner_pkg::obstacles_t nxt;
		logic [6:0]             top;
		bit                     frame;
		bit                     move;
		bit                     spawn;
		bit                     hit;
		int                     slot;
		@(posedge clock);
		frame = (m_cycle == runner_pkg::FRAME_CYCLES - 1) && !m_over;
		move  = frame && (m_frame == runner_pkg::MOVE_FRAMES - 1);
		spawn = move && (m_spawn_cnt == runner_pkg::SPAWN_MOVES - 1);
		case (m_height)
			0:       top = runner_pkg::TOP_TALL;
			1:       top = runner_pkg::TOP_MID;
			default: top = runner_pkg::TOP_SHORT;
		endcase
		hit = 1'b0;
		for (int i = 0; i < runner_pkg::NUM_SLOTS; i++) begin
			if (m_obs[i].valid && int'(m_obs[i].x) == int'(player.x) + runner_pkg::PLAYER_REACH
				&& int'(player.y) + runner_pkg::PLAYER_REACH > int'(m_obs[i].top))
				hit = 1'b1;
		end
		if (move) begin
			slot = -1;
			for (int i = 0; i < runner_pkg::NUM_SLOTS; i++)
				if (!m_obs[i].valid)
					slot = i; // highest free slot
			for (int i = 0; i < runner_pkg::NUM_SLOTS; i++)
				if (m_obs[i].valid && m_obs[i].x == 0)
					slot = i; // a leaving slot takes priority
			nxt = m_obs;
			for (int i = 0; i < runner_pkg::NUM_SLOTS; i++) begin
				if (m_obs[i].valid && m_obs[i].x == 0)
					nxt[i] = '0;
				else if (m_obs[i].valid)
					nxt[i].x = m_obs[i].x - 1;
			end
			if (spawn && slot >= 0) begin
				nxt[slot].valid = 1'b1;
				nxt[slot].x     = runner_pkg::FIELD_X;
				nxt[slot].top   = top;
			end
			m_obs = nxt;
			m_spawn_cnt = (m_spawn_cnt + 1) % runner_pkg::SPAWN_MOVES;
		end
		if (frame) begin
			m_frame = (m_frame + 1) % runner_pkg::MOVE_FRAMES;
			if (m_score_frames == runner_pkg::SCORE_FRAMES - 1)
				m_score = (m_score + 1) % 1000;
			m_score_frames = (m_score_frames + 1) % runner_pkg::SCORE_FRAMES;
		end
		if (!m_over)
			m_cycle = (m_cycle + 1) % runner_pkg::FRAME_CYCLES;
		m_height = (m_height + 1) % 3; // free-runs even after game over
		m_over = m_over || hit;
		player.x <= runner_pkg::X_W'(px);
		player.y <= runner_pkg::Y_W'(py);
	endtask

	task automatic compare_outputs(input string name);
		check_value({name, " obstacles"}, m_obs, obstacles);
		check_value({name, " score"}, expected_segs(m_score), score_segs);
		check_value({name, " game_over"}, m_over, game_over);
	endtask

	// watchdog sized from the table, one movement tick is MOVE_CYCLES clocks of 4 ns
	initial begin
		int total_moves;
		total_moves = 0;
		for (int r = 0; r < NUM_ROWS; r++)
			total_moves += row_moves[r];
		#(total_moves * MOVE_CYCLES * 4 + 400);
		$display("timeout: the run did not finish in the expected time");
		$display("ERRORS FOUND");
		$fatal(1, "watchdog expired");
	end

	initial begin
		resetn = 1'b0;
		player = '0;
		repeat (5) @(posedge clock);
		resetn <= 1'b1;
		@(negedge clock);
		check_value("reset obstacles", 64'h0, obstacles);
		check_value("reset game_over", 64'h0, game_over);
		check_value("reset score", {digit_segs[0], digit_segs[0], digit_segs[0]}, score_segs);

		for (int r = 0; r < NUM_ROWS; r++) begin
			// a row lasts a whole number of movement periods
			for (int c = 0; c < row_moves[r] * MOVE_CYCLES; c++) begin
				advance_cycle(row_px[r], row_py[r]);
				@(negedge clock);
				compare_outputs(row_name[r]);
			end
			check_value({row_name[r], " final game_over"}, row_over[r], game_over);
		end

		$display("NO ERRORS");
		$finish;
	end

endmodule

// ==== hw/runner_top.sv ====
module runner_top (
	input  logic                    clock,
	input  logic                    resetn,
	input  runner_pkg::player_t     player,
	output runner_pkg::obstacles_t  obstacles,
	output logic                    game_over,
	output runner_pkg::score_segs_t score_segs
);

	logic               frame_tick;
	logic               move_tick;
	runner_pkg::spawn_t spawn;

	tick_gen i_tick_gen (
		.clock      (clock),
		.resetn     (resetn),
		.game_over  (game_over), // stops every tick
		.frame_tick (frame_tick),
		.move_tick  (move_tick)
	);

	spawn_picker i_spawn_picker (
		.clock     (clock),
		.resetn    (resetn),
		.move_tick (move_tick),
		.spawn     (spawn)
	);

	obstacle_tracker i_obstacle_tracker (
		.clock     (clock),
		.resetn    (resetn),
		.move_tick (move_tick),
		.spawn     (spawn),
		.obstacles (obstacles)
	);

	hit_detector i_hit_detector (
		.clock     (clock),
		.resetn    (resetn),
		.obstacles (obstacles),
		.player    (player),
		.game_over (game_over)
	);

	score_display i_score_display (
		.clock      (clock),
		.resetn     (resetn),
		.frame_tick (frame_tick),
		.score_segs (score_segs)
	);

endmodule

// ==== hw/score_display.sv ====
module score_display (
	input  logic                    clock,
	input  logic                    resetn,
	input  logic                    frame_tick,
	output runner_pkg::score_segs_t score_segs
);

	logic [runner_pkg::SCORE_W-1:0] frame_cnt;
	logic [3:0]                     ones;
	logic [3:0]                     tens;
	logic [3:0]                     hundreds;
	logic                           group_done;

	function automatic logic [6:0] seg_of(input logic [3:0] digit);
		return (digit <= 4'd9) ? runner_pkg::SEG_DIGITS[digit] : 7'h7f; // blank if not bcd
	endfunction

	assign group_done = frame_tick
		&& frame_cnt == runner_pkg::SCORE_W'(runner_pkg::SCORE_FRAMES - 1);

	// bcd score with carry into the next digit, wraps 999 to 000
	always_ff @(posedge clock or negedge resetn) begin
		if (!resetn) begin
			frame_cnt <= '0;
			ones      <= '0;
			tens      <= '0;
			hundreds  <= '0;
		end else begin
			if (frame_tick)
				frame_cnt <= group_done ? '0 : frame_cnt + 1'b1;
			if (group_done) begin
				if (ones != 4'd9) begin
					ones <= ones + 4'd1;
				end else begin
					ones <= '0;
					if (tens != 4'd9) begin
						tens <= tens + 4'd1;
					end else begin
						tens     <= '0;
						hundreds <= (hundreds == 4'd9) ? 4'd0 : hundreds + 4'd1;
					end
				end
			end
		end
	end

	assign score_segs.ones     = seg_of(ones);
	assign score_segs.tens     = seg_of(tens);
	assign score_segs.hundreds = seg_of(hundreds);

endmodule

// ==== hw/hit_detector.sv ====
module hit_detector (
	input  logic                   clock,
	input  logic                   resetn,
	input  runner_pkg::obstacles_t obstacles,
	input  runner_pkg::player_t    player,
	output logic                   game_over
);

	logic [runner_pkg::X_W:0] reach_x; // one extra bit so the sum cannot wrap
	logic [runner_pkg::Y_W:0] reach_y;
	logic                     hit;

	assign reach_x = {1'b0, player.x} + (runner_pkg::X_W + 1)'(runner_pkg::PLAYER_REACH);
	assign reach_y = {1'b0, player.y} + (runner_pkg::Y_W + 1)'(runner_pkg::PLAYER_REACH);

	// a box hits when it reaches the player column and its top is above the player
	always_comb begin
		hit = 1'b0;
		for (int i = 0; i < runner_pkg::NUM_SLOTS; i++) begin
			if (obstacles[i].valid && {1'b0, obstacles[i].x} == reach_x
				&& reach_y > {1'b0, obstacles[i].top})
				hit = 1'b1;
		end
	end

	always_ff @(posedge clock or negedge resetn) begin
		if (!resetn)
			game_over <= 1'b0;
		else if (hit)
			game_over <= 1'b1; // held until reset
	end

endmodule

// ==== hw/obstacle_tracker.sv ====
module obstacle_tracker (
	input  logic                   clock,
	input  logic                   resetn,
	input  logic                   move_tick,
	input  runner_pkg::spawn_t     spawn,
	output runner_pkg::obstacles_t obstacles
);

	runner_pkg::obstacles_t        next_obs;
	logic [runner_pkg::SLOT_W-1:0] reuse_idx;
	logic [runner_pkg::SLOT_W-1:0] free_idx;
	logic [runner_pkg::SLOT_W-1:0] spawn_idx;
	logic                          reuse_hit;
	logic                          free_hit;

	// later slots override earlier ones so the highest index wins
	always_comb begin
		reuse_idx = '0;
		free_idx  = '0;
		reuse_hit = 1'b0;
		free_hit  = 1'b0;
		for (int i = 0; i < runner_pkg::NUM_SLOTS; i++) begin
			if (obstacles[i].valid && obstacles[i].x == '0) begin
				reuse_hit = 1'b1; // leaving slot, can be refilled
				reuse_idx = runner_pkg::SLOT_W'(i);
			end
			if (!obstacles[i].valid) begin
				free_hit = 1'b1;
				free_idx = runner_pkg::SLOT_W'(i);
			end
		end
		spawn_idx = reuse_hit ? reuse_idx : free_idx;
	end

	always_comb begin
		next_obs = obstacles;
		for (int i = 0; i < runner_pkg::NUM_SLOTS; i++) begin
			if (obstacles[i].valid) begin
				if (obstacles[i].x == '0)
					next_obs[i] = '0; // reached the left edge
				else
					next_obs[i].x = obstacles[i].x - 1'b1;
			end
		end
		// with every slot busy and none leaving the spawn is lost
		if (spawn.valid && (reuse_hit || free_hit)) begin
			next_obs[spawn_idx].valid = 1'b1;
			next_obs[spawn_idx].x     = runner_pkg::X_W'(runner_pkg::FIELD_X);
			next_obs[spawn_idx].top   = spawn.top;
		end
	end

	always_ff @(posedge clock or negedge resetn) begin
		if (!resetn)
			obstacles <= '0;
		else if (move_tick)
			obstacles <= next_obs;
	end

	for (genvar i = 0; i < runner_pkg::NUM_SLOTS; i++) begin : g_slot_chk
		idle_slot_zero: assert property (@(posedge clock) disable iff (!resetn)
			!obstacles[i].valid |-> obstacles[i].x == '0);
	end

endmodule

// ==== hw/spawn_picker.sv ====
module spawn_picker (
	input  logic               clock,
	input  logic               resetn,
	input  logic               move_tick,
	output runner_pkg::spawn_t spawn
);

	logic [runner_pkg::SPAWN_W-1:0] move_cnt;
	logic [1:0]                     height_sel; // free-running mod-3 counter
	logic                           move_last;

	assign move_last = move_cnt == runner_pkg::SPAWN_W'(runner_pkg::SPAWN_MOVES - 1);

	always_ff @(posedge clock or negedge resetn) begin
		if (!resetn) begin
			move_cnt   <= '0;
			height_sel <= '0;
		end else begin
			height_sel <= (height_sel == 2'd2) ? 2'd0 : height_sel + 2'd1;
			if (move_tick)
				move_cnt <= move_last ? '0 : move_cnt + 1'b1;
		end
	end

	// the height is whatever the mod-3 counter shows at the spawn tick
	always_comb begin
		spawn.valid = move_tick && move_last;
		case (height_sel)
			2'd0:    spawn.top = runner_pkg::Y_W'(runner_pkg::TOP_TALL);
			2'd1:    spawn.top = runner_pkg::Y_W'(runner_pkg::TOP_MID);
			2'd2:    spawn.top = runner_pkg::Y_W'(runner_pkg::TOP_SHORT);
			default: spawn.top = '0;
		endcase
	end

	legal_top: assert property (@(posedge clock) disable iff (!resetn)
		spawn.valid |-> spawn.top inside {runner_pkg::TOP_SHORT, runner_pkg::TOP_MID,
			runner_pkg::TOP_TALL});

endmodule

// ==== hw/tick_gen.sv ====
module tick_gen (
	input  logic clock,
	input  logic resetn,
	input  logic game_over,
	output logic frame_tick,
	output logic move_tick
);

	logic [runner_pkg::CYCLE_W-1:0] cycle_cnt;
	logic [runner_pkg::MOVE_W-1:0]  frame_cnt;
	logic                           cycle_last;
	logic                           frame_last;

	assign cycle_last = cycle_cnt == runner_pkg::CYCLE_W'(runner_pkg::FRAME_CYCLES - 1);
	assign frame_last = frame_cnt == runner_pkg::MOVE_W'(runner_pkg::MOVE_FRAMES - 1);

	// both counters freeze once the game is over
	always_ff @(posedge clock or negedge resetn) begin
		if (!resetn) begin
			cycle_cnt <= '0;
			frame_cnt <= '0;
		end else if (!game_over) begin
			cycle_cnt <= cycle_last ? '0 : cycle_cnt + 1'b1;
			if (cycle_last)
				frame_cnt <= frame_last ? '0 : frame_cnt + 1'b1;
		end
	end

	assign frame_tick = cycle_last && !game_over; // suppressed from the cycle game_over rises
	assign move_tick  = frame_tick && frame_last;

	frame_single: assert property (@(posedge clock) disable iff (!resetn)
		frame_tick |=> !frame_tick);

endmodule

// ==== hw/runner_pkg.sv ====
package runner_pkg;

	// tick rates, kept small so the game runs quickly in simulation
	localparam int FRAME_CYCLES = 4;  // clocks per frame tick
	localparam int MOVE_FRAMES  = 2;  // frame ticks per movement tick
	localparam int SPAWN_MOVES  = 20; // movement ticks between spawns
	localparam int SCORE_FRAMES = 8;  // frame ticks per score step

	localparam int NUM_SLOTS = 4;

	// counter widths derived from the rates above
	localparam int CYCLE_W = $clog2(FRAME_CYCLES);
	localparam int MOVE_W  = $clog2(MOVE_FRAMES);
	localparam int SPAWN_W = $clog2(SPAWN_MOVES);
	localparam int SCORE_W = $clog2(SCORE_FRAMES);
	localparam int SLOT_W  = $clog2(NUM_SLOTS);

	localparam int X_W = 8;
	localparam int Y_W = 7;

	localparam int FIELD_X      = 160; // entry column at the right edge
	localparam int PLAYER_REACH = 3;

	// top rows of the three obstacle heights, smaller row means taller box
	localparam int TOP_SHORT = 90;
	localparam int TOP_MID   = 70;
	localparam int TOP_TALL  = 60;

	// active-low digit patterns with segment a in bit 0
	localparam logic [0:9][6:0] SEG_DIGITS = '{
		7'b100_0000, // 0
		7'b111_1001,
		7'b010_0100,
		7'b011_0000,
		7'b001_1001,
		7'b001_0010, // 5
		7'b000_0010,
		7'b111_1000,
		7'b000_0000,
		7'b001_1000
	};

	typedef struct packed {
		logic           valid;
		logic [X_W-1:0] x;
		logic [Y_W-1:0] top;
	} obstacle_t;

	typedef obstacle_t [NUM_SLOTS-1:0] obstacles_t;

	typedef struct packed {
		logic [X_W-1:0] x;
		logic [Y_W-1:0] y;
	} player_t;

	typedef struct packed {
		logic           valid;
		logic [Y_W-1:0] top;
	} spawn_t;

	typedef struct packed {
		logic [6:0] ones;
		logic [6:0] tens;
		logic [6:0] hundreds;
	} score_segs_t;

endpackage
